/* Makefile */
# Verilator flow for the interval timer peripheral

TOP = timer_periph_tb

.PHONY: all lint build sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module timer_periph

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)

# pass only if the testbench printed its pass line
sim: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* logic/regfile_dp.sv */
`timescale 1ns/1ns
`include "timer_macros.svh"

// dual port register file
// registered read response on the cpu bus
// combinational read and next edge write on the logic side
module regfile_dp
   import timer_pkg::*;
   (
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // cpu bus
   input  logic                     cpu_avalid_i,
   input  logic [`TIMER_ADDR_W-1:0] cpu_addr_i,
   input  logic                     cpu_wen_i,
   input  logic [`TIMER_REG_W-1:0]  cpu_wdata_i,
   output logic                     cpu_rvalid_o,
   output logic [`TIMER_REG_W-1:0]  cpu_rdata_o,

   // timer engine side
   regfile_logic_if.regfile         logic_if
);

   localparam reg_idx_t cpu_wr_last = reg_idx_t'(`TIMER_CPU_WR_LAST);

   // register storage
   logic [`TIMER_REG_W-1:0] regs      [`TIMER_N_REGS];
   logic [`TIMER_REG_W-1:0] reg_wdata [`TIMER_N_REGS];
   logic [`TIMER_N_REGS-1:0] reg_wen;

   reg_idx_t cpu_idx;
   logic     cpu_aligned;
   logic     cpu_wr_ok;
   logic     cpu_rd_req;
   logic     logic_wr_ok;

   // byte address to word index
   assign cpu_idx     = cpu_addr_i[`TIMER_ADDR_W-1:2];
   assign cpu_aligned = (cpu_addr_i[1:0] == 2'b00);

   // cpu owns the low words and the logic port the high ones
   assign cpu_wr_ok   = cpu_avalid_i & cpu_wen_i & cpu_aligned & (cpu_idx <= cpu_wr_last);
   assign logic_wr_ok = logic_if.wen & (logic_if.addr > cpu_wr_last);

   assign cpu_rd_req  = cpu_avalid_i & ~cpu_wen_i;

   // per word write select
   always_comb begin
      for (int k = 0; k < `TIMER_N_REGS; k++) begin
         reg_wen[k]   = 1'b0;
         reg_wdata[k] = cpu_wdata_i;
         if (cpu_wr_ok && (cpu_idx == reg_idx_t'(k))) begin
            reg_wen[k] = 1'b1;
         end else if (logic_wr_ok && (logic_if.addr == reg_idx_t'(k))) begin
            reg_wen[k]   = 1'b1;
            reg_wdata[k] = logic_if.wdata;
         end
      end
   end

   // index ranges are disjoint so the two ports never collide
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int k = 0; k < `TIMER_N_REGS; k++) begin
            regs[k] <= '0;
         end
      end else begin
         for (int k = 0; k < `TIMER_N_REGS; k++) begin
            if (reg_wen[k]) begin
               regs[k] <= reg_wdata[k];
            end
         end
      end
   end

   // read response one cycle after the request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cpu_rvalid_o <= 1'b0;
      end else begin
         cpu_rvalid_o <= cpu_rd_req;
      end
   end

   // rdata holds until the next read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cpu_rdata_o <= '0;
      end else if (cpu_rd_req) begin
         cpu_rdata_o <= regs[cpu_idx]; // low address bits ignored on reads
      end
   end

   // logic port read, same cycle
   assign logic_if.rdata = regs[logic_if.addr];

endmodule

/* logic/regfile_logic_if.sv */
`timescale 1ns/1ns
`include "timer_macros.svh"

// logic side port of the register file
// one access per cycle with no handshake
interface regfile_logic_if
   import timer_pkg::*;
   ();

   reg_idx_t                addr;
   logic                    wen;   // write lands at next edge
   logic [`TIMER_REG_W-1:0] wdata;
   logic [`TIMER_REG_W-1:0] rdata; // combinational from addr

   modport engine (
      output addr,
      output wen,
      output wdata,
      input  rdata
   );

   modport regfile (
      input  addr,
      input  wen,
      input  wdata,
      output rdata
   );

endinterface

/* logic/timer_engine.sv */
`timescale 1ns/1ns
`include "timer_macros.svh"

// interval timer engine
// round robin over the logic port with one access per cycle
//   phase 0 read CTRL, 1 read PERIOD, 2 write COUNT, 3 write EVENTS
module timer_engine
   import timer_pkg::*;
   (
   input  logic           clk_i,
   input  logic           rst_n_i,
   regfile_logic_if.engine logic_if
);

   localparam logic [1:0] ph_rd_ctrl   = 2'd0;
   localparam logic [1:0] ph_rd_period = 2'd1;
   localparam logic [1:0] ph_wr_count  = 2'd2;

   logic [1:0] phase_q;

   // configuration captured at the start of each round
   ctrl_reg_u               ctrl_q;
   logic [`TIMER_REG_W-1:0] period_q;

   // running state
   logic [`TIMER_REG_W-1:0] count_q;
   logic [`TIMER_REG_W-1:0] events_q;
   logic [`TIMER_REG_W-1:0] count_nxt;
   logic [`TIMER_REG_W-1:0] events_nxt;

   // free running phase sequencer
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         phase_q <= ph_rd_ctrl;
      end else begin
         phase_q <= phase_q + 2'd1; // wraps back to ph_rd_ctrl
      end
   end

   // snapshot of CTRL and PERIOD
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q.raw <= '0;
         period_q   <= '0;
      end else begin
         if (phase_q == ph_rd_ctrl) begin
            ctrl_q.raw <= logic_if.rdata;
         end
         if (phase_q == ph_rd_period) begin
            period_q <= logic_if.rdata;
         end
      end
   end

   // counter rule
   always_comb begin
      count_nxt  = count_q;
      events_nxt = events_q;
      if (ctrl_q.fields.clear) begin
         count_nxt  = '0;
         events_nxt = '0;
      end else if (ctrl_q.fields.enable) begin
         if (count_q == period_q) begin
            count_nxt  = '0;
            events_nxt = events_q + 1; // wraps at full width
         end else begin
            count_nxt = count_q + 1;
         end
      end
   end

   // state advances once per round
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q  <= '0;
         events_q <= '0;
      end else if (phase_q == ph_wr_count) begin
         count_q  <= count_nxt;
         events_q <= events_nxt;
      end
   end

   // port drive per phase
   always_comb begin
      logic_if.wen   = 1'b0;
      logic_if.wdata = count_nxt;
      case (phase_q)
         ph_rd_ctrl: begin
            logic_if.addr = reg_idx_t'(`TIMER_CTRL_IDX);
         end
         ph_rd_period: begin
            logic_if.addr = reg_idx_t'(`TIMER_PERIOD_IDX);
         end
         ph_wr_count: begin
            logic_if.addr = reg_idx_t'(`TIMER_COUNT_IDX);
            logic_if.wen  = 1'b1; // new count, same cycle as the update
         end
         default: begin
            logic_if.addr  = reg_idx_t'(`TIMER_EVENTS_IDX);
            logic_if.wen   = 1'b1;
            logic_if.wdata = events_q; // already updated one cycle earlier
         end
      endcase
   end

endmodule

/* logic/timer_macros.svh */
`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// register file geometry
`define TIMER_N_REGS 4
`define TIMER_REG_W 32 // also the cpu bus data width
`define TIMER_ADDR_W 4 // byte address
`define TIMER_IDX_W 2

// word indices of the register map
`define TIMER_CTRL_IDX 0
`define TIMER_PERIOD_IDX 1
`define TIMER_COUNT_IDX 2
`define TIMER_EVENTS_IDX 3

// cpu may write indices 0..this and the logic port the rest
`define TIMER_CPU_WR_LAST 1

`endif

/* logic/timer_periph.sv */
`timescale 1ns/1ns
`include "timer_macros.svh"

// interval timer peripheral top
// cpu bus into the register file and the timer engine on the second port
module timer_periph (
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // cpu native bus which is always ready
   input  logic                     cpu_avalid_i,
   input  logic [`TIMER_ADDR_W-1:0] cpu_addr_i,
   input  logic                     cpu_wen_i,
   input  logic [`TIMER_REG_W-1:0]  cpu_wdata_i,
   output logic                     cpu_rvalid_o,
   output logic [`TIMER_REG_W-1:0]  cpu_rdata_o
);

   // engine to register file
   regfile_logic_if logic_bus ();

   regfile_dp i_regfile_dp (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cpu_avalid_i (cpu_avalid_i),
      .cpu_addr_i   (cpu_addr_i),
      .cpu_wen_i    (cpu_wen_i),
      .cpu_wdata_i  (cpu_wdata_i),
      .cpu_rvalid_o (cpu_rvalid_o),
      .cpu_rdata_o  (cpu_rdata_o),
      .logic_if     (logic_bus.regfile)
   );

   timer_engine i_timer_engine (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .logic_if (logic_bus.engine)
   );

endmodule

/* logic/timer_pkg.sv */
`include "timer_macros.svh"

package timer_pkg;

   // word index into the register file
   typedef logic [`TIMER_IDX_W-1:0] reg_idx_t;

   // field view of the CTRL word
   typedef struct packed {
      logic [`TIMER_REG_W-3:0] reserved; // reads back as written
      logic                    clear;    // bit 1
      logic                    enable;   // bit 0
   } ctrl_fields_t;

   // CTRL as stored (raw) or as decoded by the timer (fields)
   typedef union packed {
      logic [`TIMER_REG_W-1:0] raw;
      ctrl_fields_t            fields;
   } ctrl_reg_u;

endpackage

/* project.f */
+incdir+logic
logic/timer_pkg.sv
logic/regfile_logic_if.sv
logic/regfile_dp.sv
logic/timer_engine.sv
logic/timer_periph.sv
sim/timer_periph_tb.sv

/* sim/timer_periph_tb.sv */
`timescale 1ns/1ns
`include "timer_macros.svh"

module timer_periph_tb;

   localparam int clk_period    = 8;
   localparam int n_rw          = 16; // random write/read rounds
   localparam int n_count       = 12; // samples while counting
   localparam int max_gap       = 15;
   localparam int test_cycles   = 8 + n_rw * 10 + n_count * (max_gap + 12) + 300;
   localparam int margin_cycles = 200;

   localparam logic [`TIMER_ADDR_W-1:0] addr_ctrl   = {2'(`TIMER_CTRL_IDX), 2'b00};
   localparam logic [`TIMER_ADDR_W-1:0] addr_period = {2'(`TIMER_PERIOD_IDX), 2'b00};
   localparam logic [`TIMER_ADDR_W-1:0] addr_count  = {2'(`TIMER_COUNT_IDX), 2'b00};
   localparam logic [`TIMER_ADDR_W-1:0] addr_events = {2'(`TIMER_EVENTS_IDX), 2'b00};

   // one outstanding read with the value expected at request time
   typedef struct packed {
      logic [`TIMER_ADDR_W-1:0] addr;
      logic                     exact; // value known exactly
      logic [`TIMER_REG_W-1:0]  value;
      logic [31:0]              cycle;
   } read_req_t;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     cpu_avalid;
   logic [`TIMER_ADDR_W-1:0] cpu_addr;
   logic                     cpu_wen;
   logic [`TIMER_REG_W-1:0]  cpu_wdata;
   logic                     cpu_rvalid;
   logic [`TIMER_REG_W-1:0]  cpu_rdata;

   logic [`TIMER_REG_W-1:0] model_regs [`TIMER_N_REGS];
   bit                      exact_regs [`TIMER_N_REGS];
   logic [`TIMER_REG_W-1:0] seen       [`TIMER_N_REGS]; // last read data per word
   logic [31:0]             seen_at    [`TIMER_N_REGS]; // its request cycle
   read_req_t               pending    [$];
   logic [31:0]             cycle_cnt = '0;
   int                      errors;
   int                      n_reads;

   timer_periph i_timer_periph (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .cpu_avalid_i (cpu_avalid),
      .cpu_addr_i   (cpu_addr),
      .cpu_wen_i    (cpu_wen),
      .cpu_wdata_i  (cpu_wdata),
      .cpu_rvalid_o (cpu_rvalid),
      .cpu_rdata_o  (cpu_rdata)
   );

   always #(clk_period / 2) clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

   // reads return the word selected by addr[3:2]
   function automatic logic [`TIMER_REG_W-1:0] expected_read(
      input logic [`TIMER_ADDR_W-1:0] rd_addr);
      return model_regs[rd_addr[3:2]];
   endfunction

   // count runs 0..PERIOD before each event
   function automatic longint total_count(input logic [31:0] evt, input logic [31:0] cnt,
                                          input logic [31:0] per);
      return longint'(evt) * (longint'(per) + 64'sd1) + longint'(cnt);
   endfunction

   task automatic cpu_write(input logic [`TIMER_ADDR_W-1:0] wr_addr,
                            input logic [`TIMER_REG_W-1:0] wr_data);
      @(posedge clk);
      #1;
      cpu_avalid = 1'b1;
      cpu_wen    = 1'b1;
      cpu_addr   = wr_addr;
      cpu_wdata  = wr_data;
      // only aligned writes to cpu owned words land
      if (wr_addr[1:0] == 2'b00 && int'(wr_addr[3:2]) <= `TIMER_CPU_WR_LAST) begin
         model_regs[wr_addr[3:2]] = wr_data;
      end
   endtask

   task automatic cpu_read(input logic [`TIMER_ADDR_W-1:0] rd_addr);
      read_req_t req;
      @(posedge clk);
      #1;
      cpu_avalid = 1'b1;
      cpu_wen    = 1'b0;
      cpu_addr   = rd_addr;
      req.addr   = rd_addr;
      req.exact  = exact_regs[rd_addr[3:2]];
      req.value  = expected_read(rd_addr);
      req.cycle  = cycle_cnt;
      pending.push_back(req);
   endtask

   task automatic idle_cycles(input int n);
      @(posedge clk);
      #1;
      cpu_avalid = 1'b0;
      cpu_wen    = 1'b0;
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_responses();
      @(posedge clk);
      #1;
      cpu_avalid = 1'b0;
      cpu_wen    = 1'b0;
      while (pending.size() != 0) begin
         @(posedge clk);
      end
   endtask

   // frozen counters become the model
   task automatic capture_counters();
      cpu_read(addr_count);
      cpu_read(addr_events);
      wait_responses();
      model_regs[`TIMER_COUNT_IDX]  = seen[`TIMER_COUNT_IDX];
      model_regs[`TIMER_EVENTS_IDX] = seen[`TIMER_EVENTS_IDX];
      exact_regs[`TIMER_COUNT_IDX]  = 1'b1;
      exact_regs[`TIMER_EVENTS_IDX] = 1'b1;
   endtask

   task automatic reset_values();
      for (int k = 0; k < `TIMER_N_REGS; k++) begin
         cpu_read({2'(k), 2'b00}); // back to back
      end
      wait_responses();
   endtask

   task automatic rw_registers();
      exact_regs[`TIMER_COUNT_IDX]  = 1'b0; // random CTRL may start the timer
      exact_regs[`TIMER_EVENTS_IDX] = 1'b0;
      for (int i = 0; i < n_rw; i++) begin
         cpu_write(addr_ctrl, $urandom);
         cpu_write(addr_period, $urandom);
         cpu_read(addr_ctrl);
         cpu_read(addr_period);
         wait_responses();
      end
   endtask

   task automatic misaligned_writes();
      for (int off = 1; off < 4; off++) begin
         for (int w = 0; w < `TIMER_N_REGS; w++) begin
            cpu_write({2'(w), 2'(off)}, $urandom);
         end
      end
      cpu_read(addr_ctrl);
      cpu_read(addr_period);
      wait_responses();
   endtask

   task automatic read_only_guard();
      cpu_write(addr_ctrl, $urandom & ~32'h3); // enable and clear off
      idle_cycles(10);
      capture_counters();
      // each read follows its write before the engine rewrites the word
      cpu_write(addr_count, $urandom);
      cpu_read(addr_count);
      cpu_write(addr_events, $urandom);
      cpu_read(addr_events);
      wait_responses();
      idle_cycles(10);
      cpu_read(addr_count);
      cpu_read(addr_events);
      wait_responses();
   endtask

   task automatic clear_hold();
      // let both counters move away from zero first
      cpu_write(addr_period, 32'd2);
      cpu_write(addr_ctrl, 32'h1);
      idle_cycles(24);
      cpu_write(addr_ctrl, $urandom | 32'h2);
      idle_cycles(10);
      model_regs[`TIMER_COUNT_IDX]  = '0;
      model_regs[`TIMER_EVENTS_IDX] = '0;
      exact_regs[`TIMER_COUNT_IDX]  = 1'b1;
      exact_regs[`TIMER_EVENTS_IDX] = 1'b1;
      for (int i = 0; i < 3; i++) begin
         cpu_read(addr_count);
         cpu_read(addr_events);
         wait_responses();
         idle_cycles($urandom % 8);
      end
   endtask

   task automatic counting_run();
      logic [31:0] period;
      logic [31:0] cnt;
      logic [31:0] evt;
      logic [31:0] prev_at;
      longint      tot;
      longint      prev_tot;
      longint      grow;
      longint      span;
      longint      lo;
      longint      hi;
      bit          have_prev;
      period    = 32'd2 + ($urandom % 32'd8);
      have_prev = 1'b0;
      prev_tot  = 64'sd0;
      prev_at   = '0;
      exact_regs[`TIMER_COUNT_IDX]  = 1'b0;
      exact_regs[`TIMER_EVENTS_IDX] = 1'b0;
      cpu_write(addr_period, period);
      cpu_write(addr_ctrl, 32'h1);
      idle_cycles(8);
      for (int i = 0; i < n_count; i++) begin
         // COUNT then EVENTS in adjacent cycles gives a consistent pair
         cpu_read(addr_count);
         cpu_read(addr_events);
         wait_responses();
         cnt = seen[`TIMER_COUNT_IDX];
         evt = seen[`TIMER_EVENTS_IDX];
         assert (cnt <= period) else begin
            errors++;
            $display("[FAIL] cpu_rdata_o COUNT 0x%h above PERIOD 0x%h", cnt, period);
         end
         tot = total_count(evt, cnt, period);
         if (have_prev) begin
            span = longint'(seen_at[`TIMER_COUNT_IDX]) - longint'(prev_at);
            grow = tot - prev_tot;
            lo   = span / 64'sd4 - 64'sd1;
            hi   = (span + 64'sd3) / 64'sd4 + 64'sd1;
            assert (grow >= 64'sd0) else begin
               errors++;
               $display("[FAIL] cpu_rdata_o total 0x%h below previous 0x%h", tot, prev_tot);
            end
            assert (grow >= lo && grow <= hi) else begin
               errors++;
               $display("[FAIL] cpu_rdata_o total grew 0x%h in 0x%h cycles, range 0x%h..0x%h",
                        grow, span, lo, hi);
            end
         end
         have_prev = 1'b1;
         prev_tot  = tot;
         prev_at   = seen_at[`TIMER_COUNT_IDX];
         idle_cycles($urandom % (max_gap + 1));
      end
   endtask

   task automatic disable_hold();
      cpu_write(addr_ctrl, 32'h0);
      idle_cycles(10);
      capture_counters();
      idle_cycles(40);
      cpu_read(addr_count);
      cpu_read(addr_events);
      wait_responses();
   endtask

   // response checker on the falling edge where outputs are stable
   always @(negedge clk) begin
      read_req_t req;
      if (rst_n) begin
         if (cpu_rvalid) begin
            assert (pending.size() != 0) else begin
               errors++;
               $display("read response at cycle %0d without a pending read", cycle_cnt);
            end
            if (pending.size() != 0) begin
               req = pending.pop_front();
               n_reads++;
               assert (cycle_cnt == req.cycle + 32'd1) else begin
                  errors++;
                  $display("read of addr 0x%h requested at cycle %0d answered at cycle %0d",
                           req.addr, req.cycle, cycle_cnt);
               end
               seen[req.addr[3:2]]    = cpu_rdata;
               seen_at[req.addr[3:2]] = req.cycle;
               if (req.exact) begin
                  assert (cpu_rdata == req.value) else begin
                     errors++;
                     $display("[FAIL] cpu_rdata_o addr 0x%h: got 0x%h, expected 0x%h",
                              req.addr, cpu_rdata, req.value);
                  end
               end
            end
         end else if (pending.size() != 0) begin
            assert (cycle_cnt <= pending[0].cycle) else begin
               errors++;
               $display("no read response for addr 0x%h requested at cycle %0d",
                        pending[0].addr, pending[0].cycle);
            end
            if (cycle_cnt > pending[0].cycle) begin
               void'(pending.pop_front());
            end
         end
      end
   end

   initial begin
      rst_n      = 1'b0;
      cpu_avalid = 1'b0;
      cpu_addr   = '0;
      cpu_wen    = 1'b0;
      cpu_wdata  = '0;
      errors     = 0;
      n_reads    = 0;
      for (int k = 0; k < `TIMER_N_REGS; k++) begin
         model_regs[k] = '0;
         exact_regs[k] = 1'b1;
         seen[k]       = '0;
         seen_at[k]    = '0;
      end
      void'($urandom(32'h58857a5d));
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_values();
      rw_registers();
      misaligned_writes();
      read_only_guard();
      clear_hold();
      counting_run();
      disable_hold();
      idle_cycles(4);
      $display("reads checked: %0d, errors: %0d", n_reads, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((test_cycles + margin_cycles) * clk_period);
      $display("timeout: run not finished after %0d cycles, errors so far: %0d",
               test_cycles + margin_cycles, errors);
      $display("Errors found");
      $finish;
   end

endmodule
